// ==== design/slot_game_pkg.sv ====
package slot_game_pkg;

	////////////////////
	// Value types
	////////////////////

	// One decimal digit
	typedef logic [3:0] digit_t;

	// Four decimal digits, ones digit in the low nibble
	typedef logic [15:0] bcd4_t;

	// Credit, bet or step count in binary
	typedef logic [15:0] amount_t;

	// Reel result index, 16 outcomes
	typedef logic [3:0] outcome_t;

	// Phases of one round
	typedef enum logic [2:0] {
		PH_IDLE,
		PH_DEDUCT,
		PH_SPIN,
		PH_SHOW,
		PH_PAYOUT
	} phase_t;

	////////////////////
	// Game constants
	////////////////////

	// Phase lengths in spin strobes
	localparam int SPIN_TICKS = 75;
	localparam int SHOW_TICKS = 25;

	localparam amount_t CREDIT_START = 16'd100;
	localparam amount_t BET_START    = 16'd50;
	localparam amount_t AMOUNT_MAX   = 16'd9999;

	// Payout multipliers
	localparam amount_t MULT_PAIR    = 16'd2;
	localparam amount_t MULT_BAR     = 16'd5;
	localparam amount_t MULT_JACKPOT = 16'd25;

endpackage

// ==== design/seg_display_pkg.sv ====
package seg_display_pkg;

	import slot_game_pkg::*;

	// Segment pattern, active low, dp in bit 7
	typedef logic [7:0] seg_t;

	// Digit select, active low, leftmost digit in bit 3
	typedef logic [3:0] anode_t;

	////////////////////
	// Segment codes
	////////////////////
	localparam seg_t SEG_0      = 8'b11000000;
	localparam seg_t SEG_1      = 8'b11111001;
	localparam seg_t SEG_2      = 8'b10100100;
	localparam seg_t SEG_3      = 8'b10110000;
	localparam seg_t SEG_4      = 8'b10011001;
	localparam seg_t SEG_5      = 8'b10010010;
	localparam seg_t SEG_6      = 8'b10000010;
	localparam seg_t SEG_7      = 8'b11111000;
	localparam seg_t SEG_8      = 8'b10000000;
	localparam seg_t SEG_9      = 8'b10011000;
	localparam seg_t SEG_HYPHEN = 8'b10111111;
	localparam seg_t SEG_BLANK  = 8'b11111111;

	// Digit code that shows as a hyphen
	localparam digit_t SYM_HYPHEN = 4'd15;

endpackage

// ==== design/round_fsm.sv ====
`timescale 1ns/1ns

module round_fsm
	import slot_game_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     mode,
	input  logic     spin,
	input  logic     spin_tick,
	input  amount_t  credit,
	input  amount_t  bet,
	input  outcome_t outcome,
	input  logic     timer_done,
	output phase_t   phase,
	output logic     credit_inc,
	output logic     credit_dec,
	output logic     timer_start,
	output logic     roll_en,
	output logic     latch
);

	// Credit steps left to deduct or pay out
	amount_t steps;
	amount_t payout;

	// Multiplier for each outcome group
	function automatic amount_t mult_of(input outcome_t res);
		if (res < 4'd8)
			return '0;
		else if (res < 4'd12)
			return MULT_PAIR;
		else if (res < 4'd15)
			return MULT_BAR;
		else
			return MULT_JACKPOT;
	endfunction

	// Anything above 9999 only saturates the credit, so clip the step count there
	function automatic amount_t clip_payout(input amount_t stake, input amount_t mult);
		logic [31:0] product;
		product = 32'(stake) * 32'(mult);
		if (product > 32'(AMOUNT_MAX))
			return AMOUNT_MAX;
		else
			return amount_t'(product);
	endfunction

	assign payout  = clip_payout(bet, mult_of(outcome));
	assign roll_en = (phase == PH_SPIN);
	assign latch   = (phase == PH_SPIN) && timer_done;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase       <= PH_IDLE;
			steps       <= '0;
			credit_inc  <= 1'b0;
			credit_dec  <= 1'b0;
			timer_start <= 1'b0;
		end
		else
		begin
			credit_inc  <= 1'b0;
			credit_dec  <= 1'b0;
			timer_start <= 1'b0;
			case (phase)
				PH_IDLE:
					if (spin_tick && !mode && spin && credit >= bet)
					begin
						steps <= bet;
						phase <= PH_DEDUCT;
					end
				PH_DEDUCT:
					if (spin_tick)
					begin
						if (steps != '0)
						begin
							credit_dec <= 1'b1;
							steps      <= steps - 1'b1;
						end
						else
						begin
							phase       <= PH_SPIN;
							timer_start <= 1'b1;
						end
					end
				PH_SPIN:
					if (timer_done)
					begin
						phase       <= PH_SHOW;
						timer_start <= 1'b1;
					end
				// Outcome was latched at the end of the spin
				PH_SHOW:
					if (timer_done)
					begin
						steps <= payout;
						phase <= PH_PAYOUT;
					end
				PH_PAYOUT:
					if (spin_tick)
					begin
						if (steps != '0)
						begin
							credit_inc <= 1'b1;
							steps      <= steps - 1'b1;
						end
						else
							phase <= PH_IDLE;
					end
				default:
					phase <= PH_IDLE;
			endcase
		end
	end

	////////////////////
	// Checks
	////////////////////
	credit_pulse_excl: assert property (@(posedge clk) disable iff (reset)
		!(credit_inc && credit_dec));

	credit_pulse_phase: assert property (@(posedge clk) disable iff (reset)
		(credit_inc || credit_dec) |-> (phase inside {PH_DEDUCT, PH_PAYOUT}));

endmodule

// ==== design/phase_timer.sv ====
`timescale 1ns/1ns

module phase_timer
	import slot_game_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   start,
	input  logic   spin_tick,
	input  phase_t phase,
	output logic   done
);

	// Sized for the longer of the two phases
	logic [$clog2(SPIN_TICKS)-1:0] count;
	logic [$clog2(SPIN_TICKS)-1:0] last;
	logic counting;

	assign counting = (phase == PH_SPIN) || (phase == PH_SHOW);
	assign last     = (phase == PH_SHOW) ? ($bits(last))'(SHOW_TICKS - 1)
	                                     : ($bits(last))'(SPIN_TICKS - 1);

	// Fires on the strobe that completes the count
	assign done = counting && spin_tick && !start && (count == last);

	always_ff @(posedge clk)
	begin
		if (reset || start)
			count <= '0;
		else if (done)
			count <= '0;
		else if (counting && spin_tick)
			count <= count + 1'b1;
	end

endmodule

// ==== design/bcd_counter.sv ====
`timescale 1ns/1ns

module bcd_counter
	import slot_game_pkg::*;
#(
	parameter amount_t START_VALUE = '0
)(
	input  logic    clk,
	input  logic    reset,
	input  logic    inc,
	input  logic    dec,
	output bcd4_t   digits,
	output amount_t value
);

	bcd4_t next_digits;
	logic step_up;
	logic step_down;

	function automatic bcd4_t to_bcd(input amount_t bin);
		bcd4_t result;
		amount_t rest;
		rest = bin;
		for (int i = 0; i < 4; i++)
		begin
			result[i*4 +: 4] = digit_t'(rest % 10);
			rest = rest / 10;
		end
		return result;
	endfunction

	// Binary copy doubles as the saturation check
	assign step_up   = inc && !dec && (value != AMOUNT_MAX);
	assign step_down = dec && !inc && (value != '0);

	// Ripple the carry or borrow up from the ones digit
	always_comb
	begin : ripple_calc
		logic ripple;
		next_digits = digits;
		ripple = step_up || step_down;
		for (int i = 0; i < 4; i++)
		begin
			if (ripple && step_up)
			begin
				if (digits[i*4 +: 4] == 4'd9)
					next_digits[i*4 +: 4] = 4'd0;
				else
				begin
					next_digits[i*4 +: 4] = digits[i*4 +: 4] + 4'd1;
					ripple = 1'b0;
				end
			end
			else if (ripple && step_down)
			begin
				if (digits[i*4 +: 4] == 4'd0)
					next_digits[i*4 +: 4] = 4'd9;
				else
				begin
					next_digits[i*4 +: 4] = digits[i*4 +: 4] - 4'd1;
					ripple = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			digits <= to_bcd(START_VALUE);
			value  <= START_VALUE;
		end
		else
		begin
			digits <= next_digits;
			if (step_up)
				value <= value + 1'b1;
			else if (step_down)
				value <= value - 1'b1;
		end
	end

	digit_range: assert property (@(posedge clk) disable iff (reset)
		digits[3:0] <= 4'd9 && digits[7:4] <= 4'd9 &&
		digits[11:8] <= 4'd9 && digits[15:12] <= 4'd9);

endmodule

// ==== design/reel_roller.sv ====
`timescale 1ns/1ns

module reel_roller
	import slot_game_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     roll_en,
	input  logic     latch,
	input  logic     spin_tick,
	output outcome_t outcome,
	output bcd4_t    reel_digits
);

	// Free-running source, sampled at an unpredictable moment by the player
	logic [7:0] rnd;

	function automatic digit_t mod10(input logic [8:0] x);
		return digit_t'(x % 9'd10);
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
			rnd <= '0;
		else
			rnd <= rnd + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			reel_digits <= '0;
			outcome     <= '0;
		end
		else
		begin
			// Each reel sits at its own offset from the source
			if (roll_en && spin_tick)
			begin
				reel_digits[3:0]   <= mod10({1'b0, rnd});
				reel_digits[7:4]   <= mod10({1'b0, rnd} + 9'd6);
				reel_digits[11:8]  <= mod10({1'b0, rnd} + 9'd3);
				reel_digits[15:12] <= mod10({rnd, 1'b0});
			end
			if (latch)
				outcome <= rnd[3:0];
		end
	end

endmodule

// ==== design/seg_scan.sv ====
`timescale 1ns/1ns

module seg_scan
	import slot_game_pkg::*;
	import seg_display_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     scan_tick,
	input  logic     mode,
	input  phase_t   phase,
	input  bcd4_t    credit_digits,
	input  bcd4_t    bet_digits,
	input  bcd4_t    reel_digits,
	input  outcome_t outcome,
	output anode_t   an,
	output seg_t     seg
);

	logic [1:0] pos;
	bcd4_t source;
	digit_t cur_digit;

	// Symbol per outcome group (lose, pair, bar, jackpot)
	function automatic digit_t symbol_of(input outcome_t res);
		if (res < 4'd8)
			return SYM_HYPHEN;
		else if (res < 4'd12)
			return 4'd2;
		else if (res < 4'd15)
			return 4'd5;
		else
			return 4'd7;
	endfunction

	function automatic seg_t decode(input digit_t d);
		case (d)
			4'd0: return SEG_0;
			4'd1: return SEG_1;
			4'd2: return SEG_2;
			4'd3: return SEG_3;
			4'd4: return SEG_4;
			4'd5: return SEG_5;
			4'd6: return SEG_6;
			4'd7: return SEG_7;
			4'd8: return SEG_8;
			4'd9: return SEG_9;
			SYM_HYPHEN: return SEG_HYPHEN;
			default: return SEG_BLANK;
		endcase
	endfunction

	always_comb
	begin
		if (mode && phase == PH_IDLE)
			source = bet_digits;
		else if (phase == PH_SPIN)
			source = reel_digits;
		else if (phase == PH_SHOW)
			source = {4{symbol_of(outcome)}};
		else
			source = credit_digits;
	end

	// Position 0 is the leftmost place (thousands digit)
	assign cur_digit = source[{~pos, 2'b00} +: 4];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pos <= '0;
			an  <= 4'b1110;
			seg <= SEG_BLANK;
		end
		else if (scan_tick)
		begin
			pos <= pos + 1'b1;
			an  <= ~(4'b1000 >> pos);
			seg <= decode(cur_digit);
		end
	end

	an_one_low: assert property (@(posedge clk) disable iff (reset) $onehot(~an));

endmodule

// ==== design/slot_top.sv ====
`timescale 1ns/1ns

module slot_top
	import slot_game_pkg::*;
	import seg_display_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   mode,
	input  logic   spin,
	input  logic   up,
	input  logic   down,
	input  logic   scan_tick,
	input  logic   spin_tick,
	input  logic   adjust_tick,
	output anode_t an,
	output seg_t   seg
);

	phase_t phase;
	logic credit_inc, credit_dec;
	logic bet_inc, bet_dec, bet_adjust;
	logic timer_start, timer_done;
	logic roll_en, latch;
	bcd4_t credit_digits, bet_digits, reel_digits;
	amount_t credit_value, bet_value;
	outcome_t outcome;

	// Bet moves only in betting mode between rounds; up wins over down
	assign bet_adjust = adjust_tick && mode && (phase == PH_IDLE);
	assign bet_inc    = bet_adjust && up;
	assign bet_dec    = bet_adjust && down && !up;

	round_fsm u_fsm (.clk(clk), .reset(reset), .mode(mode), .spin(spin),
		.spin_tick(spin_tick), .credit(credit_value), .bet(bet_value), .outcome(outcome),
		.timer_done(timer_done), .phase(phase), .credit_inc(credit_inc),
		.credit_dec(credit_dec), .timer_start(timer_start), .roll_en(roll_en), .latch(latch));

	phase_timer u_timer (.clk(clk), .reset(reset), .start(timer_start),
		.spin_tick(spin_tick), .phase(phase), .done(timer_done));

	bcd_counter #(.START_VALUE(CREDIT_START)) u_credit (.clk(clk), .reset(reset),
		.inc(credit_inc), .dec(credit_dec), .digits(credit_digits), .value(credit_value));

	bcd_counter #(.START_VALUE(BET_START)) u_bet (.clk(clk), .reset(reset),
		.inc(bet_inc), .dec(bet_dec), .digits(bet_digits), .value(bet_value));

	reel_roller u_reel (.clk(clk), .reset(reset), .roll_en(roll_en), .latch(latch),
		.spin_tick(spin_tick), .outcome(outcome), .reel_digits(reel_digits));

	seg_scan u_scan (.clk(clk), .reset(reset), .scan_tick(scan_tick), .mode(mode),
		.phase(phase), .credit_digits(credit_digits), .bet_digits(bet_digits),
		.reel_digits(reel_digits), .outcome(outcome), .an(an), .seg(seg));

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 5
)(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Power-on reset, released just after a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#10 reset = 1'b0;
	end

endmodule

// ==== bench/slot_tb.sv ====
`timescale 1ns/1ns

module slot_tb
	import slot_game_pkg::*;
	import seg_display_pkg::*;
;

	logic clk, por_reset, tb_reset, reset;
	logic mode, spin, up, down, scan_tick, spin_tick, adjust_tick;
	anode_t an;
	seg_t seg;

	// Digits as the player sees them with thousands in the top nibble
	bcd4_t shown_bcd;
	int shown_num;
	int exp_num;
	logic check_en, sym_check, reel_check;
	int errors, an_errors, checks, errors_before;
	logic aborted;
	int credit_model, bet_model, k, mult;
	digit_t sym;

	assign reset = por_reset || tb_reset;

	tb_clock clkgen (.clk(clk), .reset(por_reset));

	slot_top uut (.clk(clk), .reset(reset), .mode(mode), .spin(spin), .up(up),
		.down(down), .scan_tick(scan_tick), .spin_tick(spin_tick),
		.adjust_tick(adjust_tick), .an(an), .seg(seg));

	function automatic digit_t digit_of_seg(input seg_t s);
		case (s)
			SEG_0: return 4'd0;
			SEG_1: return 4'd1;
			SEG_2: return 4'd2;
			SEG_3: return 4'd3;
			SEG_4: return 4'd4;
			SEG_5: return 4'd5;
			SEG_6: return 4'd6;
			SEG_7: return 4'd7;
			SEG_8: return 4'd8;
			SEG_9: return 4'd9;
			SEG_HYPHEN: return SYM_HYPHEN;
			default: return 4'hE;
		endcase
	endfunction

	// Multiplier per shown symbol (-1 for anything else)
	function automatic int mult_for_symbol(input digit_t d);
		case (d)
			SYM_HYPHEN: return 0;
			4'd2: return 2;
			4'd5: return 5;
			4'd7: return 25;
			default: return -1;
		endcase
	endfunction

	////////////////////
	// Display monitor
	////////////////////
	always @(negedge clk)
	begin
		if (!reset)
		begin
			case (an)
				4'b0111: shown_bcd[15:12] = digit_of_seg(seg);
				4'b1011: shown_bcd[11:8] = digit_of_seg(seg);
				4'b1101: shown_bcd[7:4] = digit_of_seg(seg);
				4'b1110: shown_bcd[3:0] = digit_of_seg(seg);
				default: ;
			endcase
			shown_num = shown_bcd[15:12] * 1000 + shown_bcd[11:8] * 100
				+ shown_bcd[7:4] * 10 + shown_bcd[3:0];
		end
	end

	////////////////////
	// Checks
	////////////////////
	display_value: assert property (@(posedge clk) disable iff (reset)
		check_en |-> (shown_bcd[15:12] <= 9 && shown_bcd[11:8] <= 9 &&
		shown_bcd[7:4] <= 9 && shown_bcd[3:0] <= 9 && shown_num == exp_num))
		else
		begin
			errors++;
			$display("FAIL t=%0t shown_value expected %0d got %h", $time, exp_num, shown_bcd);
		end

	symbol_places: assert property (@(posedge clk) disable iff (reset)
		sym_check |-> (shown_bcd[15:12] == shown_bcd[3:0] && shown_bcd[11:8] == shown_bcd[3:0]
		&& shown_bcd[7:4] == shown_bcd[3:0] && mult_for_symbol(shown_bcd[3:0]) >= 0))
		else
		begin
			errors++;
			$display("FAIL t=%0t shown_symbol expected four equal symbols got %h",
				$time, shown_bcd);
		end

	reel_range: assert property (@(posedge clk) disable iff (reset)
		reel_check |-> (shown_bcd[15:12] <= 9 && shown_bcd[11:8] <= 9 &&
		shown_bcd[7:4] <= 9 && shown_bcd[3:0] <= 9))
		else
		begin
			errors++;
			$display("FAIL t=%0t reel_digits expected 0-9 got %h", $time, shown_bcd);
		end

	anode_one_low: assert property (@(posedge clk) disable iff (reset) $onehot(~an))
		else
		begin
			an_errors++;
			$display("FAIL t=%0t an expected one low got %b", $time, an);
		end

	task automatic step(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic check_display(input int value);
		exp_num  = value;
		checks++;
		check_en = 1'b1;
		step(4);
		check_en = 1'b0;
	endtask

	// One adjust strobe in every four cycles
	task automatic adjust(input int count);
		repeat (count)
		begin
			adjust_tick = 1'b1;
			step(1);
			adjust_tick = 1'b0;
			step(3);
		end
	endtask

	task automatic wait_reset_release(input int limit);
		int n;
		n = 0;
		while (por_reset !== 1'b0 && n < limit)
		begin
			step(1);
			n++;
		end
		if (por_reset !== 1'b0)
		begin
			$display("Timeout: power-on reset never released");
			aborted = 1'b1;
		end
	endtask

	task automatic wait_phase(input phase_t target, input int limit);
		int n;
		n = 0;
		while (uut.phase != target && n < limit)
		begin
			step(1);
			n++;
		end
		if (uut.phase != target)
		begin
			$display("Timeout: phase %s never reached", target.name());
			aborted = 1'b1;
		end
	endtask

	task automatic report(input string name);
		$display("test %s: %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	task automatic play_round();
		step($urandom_range(15));
		spin = 1'b1;
		step(1);
		spin = 1'b0;
		wait_phase(PH_SPIN, 500);
		if (!aborted)
		begin
			step(6);
			checks++;
			reel_check = 1'b1;
			step(60);
			reel_check = 1'b0;
			wait_phase(PH_SHOW, 200);
		end
		if (!aborted)
		begin
			step(6);
			checks++;
			sym_check = 1'b1;
			step(4);
			sym_check = 1'b0;
			sym  = shown_bcd[3:0];
			mult = mult_for_symbol(sym);
			if (mult < 0)
				mult = 0;
			credit_model = credit_model - bet_model + bet_model * mult;
			if (credit_model > 9999)
				credit_model = 9999;
			wait_phase(PH_IDLE, 20000);
		end
		if (!aborted)
		begin
			step(8);
			check_display(credit_model);
		end
	endtask

	initial
	begin
		mode        = 1'b0;
		spin        = 1'b0;
		up          = 1'b0;
		down        = 1'b0;
		scan_tick   = 1'b1;
		spin_tick   = 1'b1;
		adjust_tick = 1'b0;
		tb_reset    = 1'b0;
		check_en    = 1'b0;
		sym_check   = 1'b0;
		reel_check  = 1'b0;
		shown_bcd   = '0;
		shown_num   = 0;
		exp_num     = 0;
		errors      = 0;
		an_errors   = 0;
		checks      = 0;
		errors_before = 0;
		aborted     = 1'b0;
		void'($urandom(89));

		// Reset values on the display
		wait_reset_release(20);
		step(10);
		check_display(100);
		mode = 1'b1;
		step(8);
		check_display(50);
		report("reset display");

		// Bet adjust and saturation
		k  = $urandom_range(1, 20);
		up = 1'b1;
		adjust(k);
		up = 1'b0;
		step(8);
		check_display(50 + k);
		down = 1'b1;
		adjust(80);
		down = 1'b0;
		step(8);
		check_display(0);
		up = 1'b1;
		adjust(10005);
		up = 1'b0;
		step(8);
		check_display(9999);
		report("bet adjust");

		// Bet of 9999 is more than the credit
		mode = 1'b0;
		step(8);
		spin = 1'b1;
		step(1);
		spin = 1'b0;
		step(20);
		check_display(100);
		report("spin refused");

		// Fresh machine with a small bet and several rounds
		tb_reset = 1'b1;
		step(5);
		tb_reset = 1'b0;
		mode = 1'b1;
		down = 1'b1;
		adjust(40);
		down = 1'b0;
		step(8);
		check_display(10);
		credit_model = 100;
		bet_model    = 10;
		mode = 1'b0;
		for (int r = 0; r < 6; r++)
		begin
			if (!aborted && credit_model >= bet_model)
				play_round();
		end
		report("rounds");
		$display("test anode scan: %0d errors", an_errors);

		if (errors == 0 && an_errors == 0 && !aborted)
		begin
			$display("checks %0d, errors %0d", checks, errors + an_errors);
			$display("TESTS PASSED");
		end
		else
		begin
			$display("checks %0d, errors %0d, aborted %0d", checks, errors + an_errors,
				aborted);
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
design/slot_game_pkg.sv
design/seg_display_pkg.sv
design/round_fsm.sv
design/phase_timer.sv
design/bcd_counter.sv
design/reel_roller.sv
design/seg_scan.sv
design/slot_top.sv
bench/tb_clock.sv
bench/slot_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = slot_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
